//--- logic/dram_cmd_pkg.sv
`default_nettype none

package dram_cmd_pkg;

	// command set on the shared bus, one command per cycle
	typedef enum logic [2:0] {
		NOP = 3'd0, // idle slot
		ACT = 3'd1, // open a row in one bank
		PRE = 3'd2, // close the open row of one bank
		RD  = 3'd3, // read one word from the open row
		WR  = 3'd4, // write one word into the open row
		REF = 3'd5  // refresh, closes every bank
	} dram_cmd_e;

	// address field widths
	localparam int BANK_W    = 2;
	localparam int ROW_W     = 4;
	localparam int COL_W     = 6;
	localparam int NUM_BANKS = 1 << BANK_W; // four banks

	// cycles from granted RD to rvalid at the array
	localparam int READ_LAT  = 2;

	// cycles between refresh requests
	localparam int REFRESH_INTERVAL = 64;
	localparam int REF_CNT_W        = $clog2(REFRESH_INTERVAL);

	// outstanding read counter, room for a full read pipeline plus one
	localparam int RD_CNT_W = $clog2(READ_LAT + 2);

endpackage

`default_nettype wire

//--- logic/txn_pkg.sv
`default_nettype none

package txn_pkg;

	import dram_cmd_pkg::*;

	// client request kind, 1 means write
	typedef enum logic {
		READ_REQ  = 1'b0,
		WRITE_REQ = 1'b1
	} req_type_e;

	localparam int DATA_W = 16;

	// bank on top, then row, then column
	localparam int ADDR_W = BANK_W + ROW_W + COL_W;

	// request queue
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

	// one queued client request
	typedef struct packed {
		req_type_e         rtype; // read or write
		logic [ADDR_W-1:0] addr;  // bank/row/col
		logic [DATA_W-1:0] data;  // write payload, unused on reads
	} txn_req_t;

endpackage

`default_nettype wire

//--- logic/cmd_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cmd_bus_if
	import dram_cmd_pkg::*, txn_pkg::*;
();

	logic              req;      // requester wants the bus, level
	dram_cmd_e         cmd;      // requested command
	logic [BANK_W-1:0] bank;
	logic [ROW_W-1:0]  row;
	logic [COL_W-1:0]  col;
	logic [DATA_W-1:0] wdata;    // payload for WR
	logic              gnt;      // same cycle grant, executes at the edge
	logic [DATA_W-1:0] rdata;    // read return
	logic              rvalid;
	dram_cmd_e         bus_cmd;  // command granted this cycle, any requester
	logic [BANK_W-1:0] bus_bank; // bank of the granted command

	modport requester (
		output req, cmd, bank, row, col, wdata,
		input  gnt, rdata, rvalid, bus_cmd, bus_bank
	);

	modport arbiter (
		input  req, cmd, bank, row, col, wdata,
		output gnt, rdata, rvalid, bus_cmd, bus_bank
	);

endinterface

`default_nettype wire

//--- logic/req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module req_queue
	import txn_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  txn_req_t push_req,
	input  logic     pop,
	output txn_req_t head,
	output logic     head_valid,
	output logic     full
);

	txn_req_t          mem [QUEUE_DEPTH]; // entry storage
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W:0]   count;             // one extra bit to tell full from empty
	logic              do_push;
	logic              do_pop;

	assign do_pop  = pop && head_valid;
	assign do_push = push && (!full || do_pop); // full queue can still take one on a pop

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_req;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign head       = mem[rd_ptr];            // visible the cycle after the first push
	assign head_valid = (count != '0);
	assign full       = (count == (QPTR_W + 1)'(QUEUE_DEPTH));

endmodule

`default_nettype wire

//--- logic/txn_engine.sv
`timescale 1ns/1ps
`default_nettype none

module txn_engine
	import dram_cmd_pkg::*;
	import txn_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  txn_req_t          head,
	input  logic              head_valid,
	output logic              pop,
	cmd_bus_if.requester      bus,
	output logic              write_done,
	output logic              read_done,
	output logic [DATA_W-1:0] data_out
);

	typedef enum logic [1:0] {
		ST_IDLE,   // wait for a head entry, pick the command path
		ST_PRE,    // close the wrong row
		ST_ACT,    // open the target row
		ST_ACCESS  // issue RD or WR
	} state_e;

	state_e               state;
	logic [BANK_W-1:0]    head_bank;
	logic [ROW_W-1:0]     head_row;
	logic [COL_W-1:0]     head_col;
	logic [NUM_BANKS-1:0] open_valid;          // per bank, a row is open
	logic [ROW_W-1:0]     open_row [NUM_BANKS];
	logic                 row_open;
	logic                 row_hit;
	logic                 ref_seen;
	logic                 access_gnt;
	logic                 rd_gnt;
	logic                 wr_gnt;
	logic [READ_LAT-1:0]  tag_sr;              // one bit per cycle of read latency

	// address split, bank on top
	assign head_bank = head.addr[ADDR_W-1 -: BANK_W];
	assign head_row  = head.addr[COL_W +: ROW_W];
	assign head_col  = head.addr[COL_W-1:0];

	assign row_open = open_valid[head_bank];
	assign row_hit  = row_open && (open_row[head_bank] == head_row);
	assign ref_seen = (bus.bus_cmd == REF); // refresh granted to the other requester

	assign access_gnt = (state == ST_ACCESS) && bus.gnt;
	assign rd_gnt     = access_gnt && (head.rtype == READ_REQ);
	assign wr_gnt     = access_gnt && (head.rtype == WRITE_REQ);
	assign pop        = access_gnt; // head retires with its access command

	always_comb begin
		bus.req   = (state != ST_IDLE);
		bus.bank  = head_bank;
		bus.row   = head_row;
		bus.col   = head_col;
		bus.wdata = head.data;
		case (state)
			ST_PRE:    bus.cmd = PRE;
			ST_ACT:    bus.cmd = ACT;
			ST_ACCESS: bus.cmd = (head.rtype == WRITE_REQ) ? WR : RD;
			default:   bus.cmd = NOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			open_valid <= '0;
		end else if (ref_seen) begin
			open_valid <= '0;                  // refresh closed every row
			if (state != ST_IDLE) state <= ST_ACT; // reopen before the access
		end else begin
			case (state)
				ST_IDLE: if (head_valid) begin
					if (row_hit)       state <= ST_ACCESS;
					else if (row_open) state <= ST_PRE; // conflict
					else               state <= ST_ACT; // bank closed
				end
				ST_PRE: if (bus.gnt) begin
					open_valid[bus.bus_bank] <= 1'b0;
					state                    <= ST_ACT;
				end
				ST_ACT: if (bus.gnt) begin
					open_valid[bus.bus_bank] <= 1'b1;
					state                    <= ST_ACCESS;
				end
				ST_ACCESS: if (bus.gnt) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// row tag of each bank, qualified by open_valid
	always_ff @(posedge clk) begin
		if ((state == ST_ACT) && bus.gnt) begin
			open_row[bus.bus_bank] <= head_row;
		end
	end

	// read tags line up with rvalid, then one register stage to the client
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tag_sr     <= '0;
			write_done <= 1'b0;
			read_done  <= 1'b0;
			data_out   <= '0;
		end else begin
			tag_sr     <= (tag_sr << 1) | READ_LAT'(rd_gnt);
			write_done <= wr_gnt;                          // cycle after WR grant
			read_done  <= bus.rvalid && tag_sr[READ_LAT-1];
			if (bus.rvalid && tag_sr[READ_LAT-1]) data_out <= bus.rdata;
		end
	end

endmodule

`default_nettype wire

//--- logic/refresh_engine.sv
`timescale 1ns/1ps
`default_nettype none

module refresh_engine
	import dram_cmd_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	cmd_bus_if.requester bus
);

	logic [REF_CNT_W-1:0] ref_cnt;     // cycles since last refresh grant
	logic                 ref_pending; // REF requested, not yet granted

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ref_cnt     <= '0;
			ref_pending <= 1'b0;
		end else if (ref_pending) begin
			// counter parked at zero, a late grant never queues a second REF
			if (bus.gnt) ref_pending <= 1'b0;
		end else if (ref_cnt == REF_CNT_W'(REFRESH_INTERVAL - 1)) begin
			ref_pending <= 1'b1;
			ref_cnt     <= '0;
		end else begin
			ref_cnt <= ref_cnt + 1'b1;
		end
	end

	// request held until granted
	assign bus.req   = ref_pending;
	assign bus.cmd   = REF;
	assign bus.bank  = '0; // all banks
	assign bus.row   = '0;
	assign bus.col   = '0;
	assign bus.wdata = '0;

endmodule

`default_nettype wire

//--- logic/cmd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter
	import dram_cmd_pkg::*;
	import txn_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	cmd_bus_if.arbiter        ref_bus,
	cmd_bus_if.arbiter        txn_bus,
	output dram_cmd_e         arr_cmd,
	output logic [BANK_W-1:0] arr_bank,
	output logic [ROW_W-1:0]  arr_row,
	output logic [COL_W-1:0]  arr_col,
	output logic [DATA_W-1:0] arr_wdata,
	input  logic [DATA_W-1:0] arr_rdata,
	input  logic              arr_rvalid
);

	logic ref_gnt;
	logic txn_gnt;

	assign ref_gnt = ref_bus.req;                  // refresh always wins
	assign txn_gnt = txn_bus.req && !ref_bus.req;
	assign ref_bus.gnt = ref_gnt;
	assign txn_bus.gnt = txn_gnt;

	always_comb begin
		arr_cmd   = NOP;
		arr_bank  = '0;
		arr_row   = '0;
		arr_col   = '0;
		arr_wdata = '0;
		if (ref_gnt) begin
			arr_cmd  = ref_bus.cmd;
			arr_bank = ref_bus.bank;
			arr_row  = ref_bus.row;
			arr_col  = ref_bus.col;
			arr_wdata = ref_bus.wdata;
		end else if (txn_gnt) begin
			arr_cmd   = txn_bus.cmd;
			arr_bank  = txn_bus.bank;
			arr_row   = txn_bus.row;
			arr_col   = txn_bus.col;
			arr_wdata = txn_bus.wdata;
		end
	end

	// granted command seen by both requesters
	assign ref_bus.bus_cmd  = arr_cmd;
	assign ref_bus.bus_bank = arr_bank;
	assign txn_bus.bus_cmd  = arr_cmd;
	assign txn_bus.bus_bank = arr_bank;

	assign txn_bus.rdata  = arr_rdata;  // read data only to the txn side
	assign txn_bus.rvalid = arr_rvalid;
	assign ref_bus.rdata  = '0;
	assign ref_bus.rvalid = 1'b0;

endmodule

`default_nettype wire

//--- logic/dram_array.sv
`timescale 1ns/1ps
`default_nettype none

module dram_array
	import dram_cmd_pkg::*;
	import txn_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  dram_cmd_e         cmd,
	input  logic [BANK_W-1:0] bank,
	input  logic [ROW_W-1:0]  row,
	input  logic [COL_W-1:0]  col,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata,
	output logic              rvalid
);

	logic [DATA_W-1:0]    mem [2**ADDR_W];     // all banks, rows, columns
	logic [NUM_BANKS-1:0] open_valid;
	logic [ROW_W-1:0]     open_row [NUM_BANKS];
	logic [ADDR_W-1:0]    acc_addr;
	logic                 acc_ok;              // target bank has a row open
	logic [READ_LAT-1:0]  rv_pipe;
	logic [DATA_W-1:0]    rd_pipe [READ_LAT];

	assign acc_addr = {bank, open_row[bank], col}; // column in the open row
	assign acc_ok   = open_valid[bank];

	// bank state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			open_valid <= '0;
		end else begin
			case (cmd)
				ACT:     open_valid[bank] <= 1'b1;
				PRE:     open_valid[bank] <= 1'b0;
				REF:     open_valid       <= '0; // all banks closed
				default: open_valid       <= open_valid;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd == ACT) open_row[bank] <= row;
		if ((cmd == WR) && acc_ok) mem[acc_addr] <= wdata; // closed bank drops the write
	end

	// fixed latency read path
	always_ff @(posedge clk) begin
		if (cmd == RD) rd_pipe[0] <= acc_ok ? mem[acc_addr] : '0;
		for (int i = 1; i < READ_LAT; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) rv_pipe <= '0;
		else        rv_pipe <= (rv_pipe << 1) | READ_LAT'(cmd == RD);
	end

	assign rdata  = rd_pipe[READ_LAT-1];
	assign rvalid = rv_pipe[READ_LAT-1]; // READ_LAT cycles after the RD

endmodule

`default_nettype wire

//--- logic/mem_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top
	import dram_cmd_pkg::*;
	import txn_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  req_type_e         in_request_type,
	input  logic [ADDR_W-1:0] in_request_address,
	input  logic [DATA_W-1:0] in_request_data,
	output logic              out_busy,
	output logic              write_done,
	output logic              read_done,
	output logic [DATA_W-1:0] data_out
);

	txn_req_t          push_req;
	txn_req_t          head;
	logic              push;
	logic              pop;
	logic              head_valid;
	logic              full;
	dram_cmd_e         arr_cmd;
	logic [BANK_W-1:0] arr_bank;
	logic [ROW_W-1:0]  arr_row;
	logic [COL_W-1:0]  arr_col;
	logic [DATA_W-1:0] arr_wdata;
	logic [DATA_W-1:0] arr_rdata;
	logic              arr_rvalid;

	cmd_bus_if ref_bus ();
	cmd_bus_if txn_bus ();

	assign push_req = '{rtype: in_request_type, addr: in_request_address, data: in_request_data};
	assign push     = in_valid && !full; // request while busy is ignored
	assign out_busy = full;

	req_queue u_queue (
		.clk, .rst_n, .push, .push_req, .pop, .head, .head_valid, .full
	);

	txn_engine u_txn (
		.clk, .rst_n, .head, .head_valid, .pop, .bus(txn_bus),
		.write_done, .read_done, .data_out
	);

	refresh_engine u_refresh (.clk, .rst_n, .bus(ref_bus));

	cmd_arbiter u_arb (
		.clk, .rst_n, .ref_bus, .txn_bus, .arr_cmd, .arr_bank, .arr_row, .arr_col,
		.arr_wdata, .arr_rdata, .arr_rvalid
	);

	dram_array u_array (
		.clk, .rst_n, .cmd(arr_cmd), .bank(arr_bank), .row(arr_row), .col(arr_col),
		.wdata(arr_wdata), .rdata(arr_rdata), .rvalid(arr_rvalid)
	);

endmodule

`default_nettype wire

//--- sim/mem_ctrl_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_asserts
	import dram_cmd_pkg::*;
(
	input logic              clk,
	input logic              rst_n,
	input logic              ref_gnt,
	input logic              txn_gnt,
	input dram_cmd_e         cmd,    // command reaching the array
	input logic [BANK_W-1:0] bank,
	input logic [ROW_W-1:0]  row,
	input logic              rvalid  // array read return
);

	logic [NUM_BANKS-1:0] mon_open;             // bank state seen from the command stream
	logic [ROW_W-1:0]     mon_row [NUM_BANKS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mon_open <= '0;
		end else begin
			case (cmd)
				ACT:     mon_open[bank] <= 1'b1;
				PRE:     mon_open[bank] <= 1'b0;
				REF:     mon_open       <= '0; // refresh closes all
				default: mon_open       <= mon_open;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd == ACT) mon_row[bank] <= row;
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd != NOP) == $onehot({ref_gnt, txn_gnt}))
		else $error("array command does not match exactly one grant");

	a_open_row: assert property (@(posedge clk) disable iff (!rst_n)
		((cmd == RD) || (cmd == WR)) |-> (mon_open[bank] && (mon_row[bank] == row)))
		else $error("access to a row that is not open, bank %0d row %0d", bank, row);

	a_act_closed: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd == ACT) |-> !mon_open[bank])
		else $error("ACT to bank %0d with a row already open", bank);

	a_read_lat: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid == ($past(cmd, READ_LAT) == RD))
		else $error("rvalid not exactly READ_LAT cycles after RD");

endmodule

`default_nettype wire

//--- sim/mem_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_tb
	import dram_cmd_pkg::*;
	import txn_pkg::*;
();

	logic              clk = 1'b0;
	logic              rst_n;
	logic              in_valid;
	req_type_e         in_request_type;
	logic [ADDR_W-1:0] in_request_address;
	logic [DATA_W-1:0] in_request_data;
	logic              out_busy;
	logic              write_done;
	logic              read_done;
	logic [DATA_W-1:0] data_out;

	logic [DATA_W-1:0] model_mem [logic [ADDR_W-1:0]]; // last word written per address
	logic [DATA_W-1:0] exp_q [$];                       // expected read data, issue order
	int                wr_acc;                          // accepted writes
	int                rd_acc;
	int                wr_done_cnt;
	int                rd_done_cnt;
	int                busy_cycles;
	int                ref_cnt;                         // granted REF commands
	int                checks;
	int                errors;
	logic              hung = 1'b0;                     // a wait loop ran out

	always #5 clk = ~clk; // 10 ns period

	mem_ctrl_top u_dut (
		.clk, .rst_n, .in_valid, .in_request_type, .in_request_address, .in_request_data,
		.out_busy, .write_done, .read_done, .data_out
	);

	bind cmd_arbiter mem_ctrl_asserts u_asserts (
		.clk, .rst_n, .ref_gnt, .txn_gnt, .cmd(arr_cmd), .bank(arr_bank), .row(arr_row),
		.rvalid(arr_rvalid)
	);

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_hang(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
		hung = 1'b1; // later waits fall through to the report
	endtask

	task automatic end_test(input string name);
		$display("test %s finished, errors so far %0d", name, errors);
	endtask

	task automatic check_idle_outputs();
		check_count("out_busy", int'(out_busy), 0);
		check_count("write_done", int'(write_done), 0);
		check_count("read_done", int'(read_done), 0);
		check_data("data_out", data_out, '0);
	endtask

	// model update at the accepting edge
	task automatic record_request();
		logic [DATA_W-1:0] exp;
		if (in_request_type == WRITE_REQ) begin
			model_mem[in_request_address] = in_request_data;
			wr_acc++;
		end else begin
			exp = model_mem.exists(in_request_address) ? model_mem[in_request_address] : '0;
			exp_q.push_back(exp);
			rd_acc++;
		end
	endtask

	task automatic take_read();
		rd_done_cnt++;
		if (exp_q.size() == 0) begin
			errors++;
			$display("read_done pulsed with no read outstanding");
		end else begin
			check_data("data_out", data_out, exp_q.pop_front());
		end
	endtask

	// outputs and inputs are all stable at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_busy) busy_cycles++;
			if (u_dut.arr_cmd == REF) ref_cnt++;
			if (in_valid && !out_busy) record_request();
			if (write_done) wr_done_cnt++;
			if (read_done) take_read();
		end
	end

	// called 1 ns after a rising edge, returns at the same phase
	task automatic send(input req_type_e t, input logic [ADDR_W-1:0] a,
			input logic [DATA_W-1:0] d);
		int n;
		n = 0;
		while (out_busy && !hung && n < 2000) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= 2000) report_hang("out_busy to drop");
		if (!hung) begin
			in_valid           = 1'b1;
			in_request_type    = t;
			in_request_address = a;
			in_request_data    = d;
			@(posedge clk); // accepted here, busy was low all cycle
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (!hung && (wr_done_cnt < wr_acc || rd_done_cnt < rd_acc) && n < 2000) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= 2000) report_hang("outstanding done pulses");
		check_count("write_done pulses", wr_done_cnt, wr_acc);
		check_count("read_done pulses", rd_done_cnt, rd_acc);
	endtask

	// two banks, three rows, eight columns: hits, misses and conflicts
	function automatic logic [ADDR_W-1:0] pick_addr();
		return {BANK_W'($urandom_range(1, 0)), ROW_W'($urandom_range(2, 0)),
			COL_W'($urandom_range(7, 0))};
	endfunction

	task automatic random_traffic(input int count);
		req_type_e         t;
		logic [ADDR_W-1:0] a;
		for (int i = 0; i < count; i++) begin
			a = pick_addr();
			t = ($urandom_range(1, 0) == 1) ? WRITE_REQ : READ_REQ;
			if (!model_mem.exists(a)) t = WRITE_REQ; // never read unwritten storage
			send(t, a, DATA_W'($urandom));
		end
	endtask

	initial begin
		int busy_before;
		int refs_before;
		void'($urandom(38129));
		rst_n              = 1'b0;
		in_valid           = 1'b0;
		in_request_type    = READ_REQ;
		in_request_address = '0;
		in_request_data    = '0;

		@(posedge clk); // first reset edge
		repeat (2) begin
			@(negedge clk);
			check_idle_outputs();
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_outputs(); // right after release
		@(posedge clk);
		#1;
		end_test("reset");

		for (int i = 0; i < 15; i++) begin
			send(WRITE_REQ, {BANK_W'(0), ROW_W'(1), COL_W'(i)}, DATA_W'($urandom));
		end
		for (int i = 0; i < 15; i++) begin
			send(READ_REQ, {BANK_W'(0), ROW_W'(1), COL_W'(i)}, '0);
		end
		drain();
		check_count("write_done total", wr_done_cnt, 15);
		check_count("read_done total", rd_done_cnt, 15);
		end_test("write_then_read");

		random_traffic(400);
		drain();
		end_test("random_mixed");

		busy_before = busy_cycles;
		random_traffic(60);
		drain();
		if (busy_cycles == busy_before) begin
			errors++;
			$display("queue never filled, back-pressure not exercised");
		end
		end_test("back_pressure");

		refs_before = ref_cnt;
		random_traffic(300);
		drain();
		if (ref_cnt - refs_before < 4) begin
			errors++;
			$display("only %0d refreshes during traffic, expected several", ref_cnt - refs_before);
		end
		check_count("reads left unanswered", exp_q.size(), 0);
		end_test("refresh");

		$display("checks %0d, errors %0d, writes %0d, reads %0d, refreshes %0d",
			checks, errors, wr_acc, rd_acc, ref_cnt);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
logic/dram_cmd_pkg.sv
logic/txn_pkg.sv
logic/cmd_bus_if.sv
logic/req_queue.sv
logic/txn_engine.sv
logic/refresh_engine.sv
logic/cmd_arbiter.sv
logic/dram_array.sv
logic/mem_ctrl_top.sv
sim/mem_ctrl_asserts.sv
sim/mem_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_ctrl_tb -f sim.f

out=$(./obj_dir/Vmem_ctrl_tb)
printf '%s\n' "$out"

# pass only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx 'Simulation passed'
